// File: hw/fe_defs.svh
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

`default_nettype none

// fetch buffer geometry, depth must be a power of two
`define FB_DEPTH 16
`define FB_PTR_W 4
`define FB_CNT_W 5

// datapath widths
`define XLEN    32
`define IMEM_AW 10
`define IMEM_DW 64
`define REG_AW  5

`default_nettype wire

`endif

// File: hw/fe_pkg.sv
`include "fe_defs.svh"
`default_nettype none

package fe_pkg;

    // major opcode, insn[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_OTHER
    } op_class_e;

    // one imem response, insn0 is the even word
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] insn0;
        logic [`XLEN-1:0] insn1;
        logic             two_valid;
    } fetch_pkt_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] insn;
    } fb_entry_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        op_class_e          op;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic               writes_rd;
        logic               reads_rs2;
    } dec_slot_t;

endpackage

`default_nettype wire

// File: hw/fetch_unit.sv
`include "fe_defs.svh"
`default_nettype none

module fetch_unit (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 redirect,
    input  wire logic [`XLEN-1:0]     redirect_pc,
    input  wire logic [`FB_CNT_W-1:0] level,
    output logic                      imem_req,
    output logic [`IMEM_AW-1:0]       imem_addr,
    input  wire logic [`IMEM_DW-1:0]  imem_rdata,
    output logic                      push,
    output fe_pkg::fetch_pkt_t        pkt
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] req_pc;
    logic             fetch_en;
    logic             pending;
    logic             mid_pair;
    logic             has_room;

    // room for the pair in flight plus the new one
    assign has_room  = (level <= `FB_CNT_W'(`FB_DEPTH - 4));
    assign imem_req  = fetch_en && has_room && !redirect;
    assign imem_addr = pc[`IMEM_AW+2:3];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc       <= '0;
            fetch_en <= 1'b0;
            pending  <= 1'b0;
        end else begin
            // idle during reset, start from pc 0 once released
            fetch_en <= 1'b1;
            if (redirect) begin
                pc      <= redirect_pc;
                pending <= 1'b0;
            end else begin
                pending <= imem_req;
                if (imem_req) begin
                    pc <= {pc[`XLEN-1:3] + 1'b1, 3'b000};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req) begin
            req_pc <= pc;
        end
    end

    // odd-word start, only the upper half is wanted
    assign mid_pair = req_pc[2];

    assign push          = pending;
    assign pkt.pc        = req_pc;
    assign pkt.insn0     = imem_rdata[`XLEN-1:0];
    assign pkt.insn1     = imem_rdata[`IMEM_DW-1:`XLEN];
    assign pkt.two_valid = !mid_pair;

endmodule

`default_nettype wire

// File: hw/fetch_buffer.sv
`include "fe_defs.svh"
`default_nettype none

module fetch_buffer (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 flush,
    input  wire logic                 push,
    input  wire fe_pkg::fetch_pkt_t   pkt,
    input  wire logic [1:0]           pop_cnt,
    output logic [`FB_CNT_W-1:0]      level,
    output fe_pkg::fb_entry_t [1:0]   head
);
    import fe_pkg::*;

    logic [`XLEN-1:0]     mem_pc   [`FB_DEPTH];
    logic [`XLEN-1:0]     mem_insn [`FB_DEPTH];
    logic [`FB_PTR_W-1:0] head_ptr;
    logic [`FB_PTR_W-1:0] head_ptr1;
    logic [`FB_PTR_W-1:0] tail_ptr;
    fb_entry_t [1:0]      wr;
    logic [1:0]           push_cnt;

    // write lanes, lane 0 holds the word at pkt.pc
    always_comb begin
        wr[0].valid = push && !flush;
        wr[0].pc    = pkt.pc;
        wr[0].insn  = pkt.two_valid ? pkt.insn0 : pkt.insn1;
        wr[1].valid = push && !flush && pkt.two_valid;
        wr[1].pc    = pkt.pc + `XLEN'd4;
        wr[1].insn  = pkt.insn1;
    end

    // lane 1 never fires without lane 0
    assign push_cnt = {wr[1].valid, wr[0].valid & ~wr[1].valid};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (wr[i].valid) begin
                mem_pc[tail_ptr + `FB_PTR_W'(i)]   <= wr[i].pc;
                mem_insn[tail_ptr + `FB_PTR_W'(i)] <= wr[i].insn;
            end
        end
    end

    // pointers wrap on their own width
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            level    <= '0;
        end else if (flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            level    <= '0;
        end else begin
            head_ptr <= head_ptr + `FB_PTR_W'(pop_cnt);
            tail_ptr <= tail_ptr + `FB_PTR_W'(push_cnt);
            level    <= level + `FB_CNT_W'(push_cnt) - `FB_CNT_W'(pop_cnt);
        end
    end

    assign head_ptr1 = head_ptr + 1'b1;

    // two oldest entries, slot 0 first
    always_comb begin
        head[0].valid = (level != '0);
        head[0].pc    = mem_pc[head_ptr];
        head[0].insn  = mem_insn[head_ptr];
        head[1].valid = (level > `FB_CNT_W'd1);
        head[1].pc    = mem_pc[head_ptr1];
        head[1].insn  = mem_insn[head_ptr1];
    end

endmodule

`default_nettype wire

// File: hw/slot_decoder.sv
`include "fe_defs.svh"
`default_nettype none

module slot_decoder (
    input  wire fe_pkg::fb_entry_t entry,
    output fe_pkg::dec_slot_t      slot
);
    import fe_pkg::*;

    logic [6:0] opcode;
    op_class_e  cls;
    logic       uses_rs2;

    assign opcode = entry.insn[6:0];

    always_comb begin
        cls      = OP_OTHER;
        uses_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                cls      = OP_ALU;
                uses_rs2 = 1'b1;
            end
            OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
                cls = OP_ALU;
            end
            OPC_LOAD: begin
                cls = OP_LOAD;
            end
            OPC_STORE: begin
                cls      = OP_STORE;
                uses_rs2 = 1'b1;
            end
            OPC_BRANCH: begin
                cls      = OP_BRANCH;
                uses_rs2 = 1'b1;
            end
            // jumps are treated as branches for pairing
            OPC_JAL, OPC_JALR: begin
                cls = OP_BRANCH;
            end
            default: begin
                cls = OP_OTHER;
            end
        endcase
    end

    // raw fields, qualified later by writes_rd and reads_rs2
    assign slot.valid     = entry.valid;
    assign slot.pc        = entry.pc;
    assign slot.op        = cls;
    assign slot.rd        = entry.insn[11:7];
    assign slot.rs1       = entry.insn[19:15];
    assign slot.rs2       = entry.insn[24:20];
    assign slot.writes_rd = (cls == OP_ALU) || (cls == OP_LOAD);
    assign slot.reads_rs2 = uses_rs2;

endmodule

`default_nettype wire

// File: hw/issue_ctrl.sv
`include "fe_defs.svh"
`default_nettype none

module issue_ctrl (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire logic               flush,
    input  wire logic               stall,
    input  wire fe_pkg::dec_slot_t [1:0] slot_in,
    output logic [1:0]              pop_cnt,
    output logic [1:0]              issue_valid,
    output fe_pkg::dec_slot_t [1:0] issue_slot
);
    import fe_pkg::*;

    dec_slot_t s0;
    dec_slot_t s1;
    logic      s0_writes;
    logic      raw_hazard;
    logic      mem_conflict;
    logic      iss0;
    logic      iss1;

    assign s0 = slot_in[0];
    assign s1 = slot_in[1];

    // x0 writes never create a dependency
    assign s0_writes  = s0.writes_rd && (s0.rd != '0);
    assign raw_hazard = s0_writes &&
                        ((s1.rs1 == s0.rd) || (s1.reads_rs2 && (s1.rs2 == s0.rd)));

    // single memory port downstream
    assign mem_conflict = (s0.op inside {OP_LOAD, OP_STORE}) &&
                          (s1.op inside {OP_LOAD, OP_STORE});

    // nothing leaves the buffer in a redirect cycle
    assign iss0 = s0.valid && !stall && !flush;
    assign iss1 = iss0 && s1.valid && (s0.op != OP_BRANCH) &&
                  !raw_hazard && !mem_conflict;

    assign pop_cnt = {iss1, iss0 & ~iss1};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_valid <= '0;
        end else begin
            issue_valid <= {iss1, iss0};
        end
    end

    always_ff @(posedge clk) begin
        if (iss0) begin
            issue_slot[0] <= s0;
        end
        if (iss1) begin
            issue_slot[1] <= s1;
        end
    end

endmodule

`default_nettype wire

// File: hw/frontend_top.sv
`include "fe_defs.svh"
`default_nettype none

module frontend_top (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                redirect,
    input  wire logic [`XLEN-1:0]    redirect_pc,
    input  wire logic                stall,
    output logic                     imem_req,
    output logic [`IMEM_AW-1:0]      imem_addr,
    input  wire logic [`IMEM_DW-1:0] imem_rdata,
    output logic [1:0]               issue_valid,
    output fe_pkg::dec_slot_t [1:0]  issue_slot
);
    import fe_pkg::*;

    logic                 push;
    fetch_pkt_t           pkt;
    logic [`FB_CNT_W-1:0] level;
    logic [1:0]           pop_cnt;
    fb_entry_t [1:0]      fb_head;
    dec_slot_t [1:0]      dec_slot;

    fetch_unit u_fetch (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .level       (level),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .push        (push),
        .pkt         (pkt)
    );

    fetch_buffer u_fbuf (
        .clk     (clk),
        .rstn    (rstn),
        .flush   (redirect),
        .push    (push),
        .pkt     (pkt),
        .pop_cnt (pop_cnt),
        .level   (level),
        .head    (fb_head)
    );

    for (genvar g = 0; g < 2; g++) begin : g_dec
        slot_decoder u_dec (
            .entry (fb_head[g]),
            .slot  (dec_slot[g])
        );
    end

    issue_ctrl u_issue (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (redirect),
        .stall       (stall),
        .slot_in     (dec_slot),
        .pop_cnt     (pop_cnt),
        .issue_valid (issue_valid),
        .issue_slot  (issue_slot)
    );

endmodule

`default_nettype wire

// File: test/tb_frontend.sv
`include "fe_defs.svh"
`default_nettype none

module tb_frontend;
    timeunit 1ns;
    timeprecision 100ps;

    import fe_pkg::*;

    localparam logic [6:0] ENC_OP    = 7'b0110011;
    localparam logic [6:0] ENC_IMM   = 7'b0010011;
    localparam logic [6:0] ENC_LUI   = 7'b0110111;
    localparam logic [6:0] ENC_LOAD  = 7'b0000011;
    localparam logic [6:0] ENC_STORE = 7'b0100011;
    localparam logic [6:0] ENC_BR    = 7'b1100011;
    localparam logic [6:0] ENC_JAL   = 7'b1101111;
    localparam logic [6:0] ENC_SYS   = 7'b1110011;

    logic                clk;
    logic                rstn;
    logic                redirect;
    logic [`XLEN-1:0]    redirect_pc;
    logic                stall;
    logic                imem_req;
    logic [`IMEM_AW-1:0] imem_addr;
    logic [`IMEM_DW-1:0] imem_rdata;
    logic [1:0]          issue_valid;
    dec_slot_t [1:0]     issue_slot;

    logic [`IMEM_DW-1:0] imem [1 << `IMEM_AW];
    logic [`IMEM_AW-1:0] rd_addr;
    logic [`XLEN-1:0]    grp_pc [$];
    bit                  grp_two [$];
    integer              seed;

    frontend_top dut (.*);

    always #5 clk = ~clk;

    // one cycle read latency
    always @(posedge clk) begin
        if (imem_req) begin
            rd_addr = imem_addr;
            #1;
            imem_rdata = imem[rd_addr];
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] make_insn(input logic [6:0] opc, input int rd,
                                              input int rs1, input int rs2);
        return {7'b0, 5'(rs2), 5'(rs1), 3'b010, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] pc);
        logic [63:0] pair;
        pair = imem[pc[`IMEM_AW+2:3]];
        return pc[2] ? pair[63:32] : pair[31:0];
    endfunction

    task automatic set_word(input logic [31:0] pc, input logic [31:0] insn);
        imem[pc[`IMEM_AW+2:3]][{pc[2], 5'b0} +: 32] = insn;
    endtask

    task automatic fill_memory();
        // both words depend on every address bit
        for (int a = 0; a < (1 << `IMEM_AW); a++) begin
            imem[a] = {make_insn(ENC_IMM, a[4:0], a[9:5], 1),
                       make_insn(ENC_IMM, a[9:5], a[4:0], 0)};
        end
    endtask

    function automatic op_class_e class_of(input logic [31:0] insn);
        case (insn[6:0])
            ENC_OP, ENC_IMM, ENC_LUI, 7'b0010111: return OP_ALU;
            ENC_LOAD: return OP_LOAD;
            ENC_STORE: return OP_STORE;
            ENC_BR, ENC_JAL, 7'b1100111: return OP_BRANCH;
            default: return OP_OTHER;
        endcase
    endfunction

    function automatic bit writes_reg(input logic [31:0] insn);
        return class_of(insn) inside {OP_ALU, OP_LOAD};
    endfunction

    function automatic bit reads_second(input logic [31:0] insn);
        return insn[6:0] inside {ENC_OP, ENC_STORE, ENC_BR};
    endfunction

    function automatic bit can_pair(input logic [31:0] a, input logic [31:0] b);
        op_class_e ca;
        op_class_e cb;
        bit        wr;
        bit        rs2_used;
        ca = class_of(a);
        cb = class_of(b);
        wr = writes_reg(a) && (a[11:7] != 5'd0);
        rs2_used = reads_second(b);
        if (ca == OP_BRANCH) return 1'b0;
        if (wr && (b[19:15] == a[11:7] || (rs2_used && b[24:20] == a[11:7]))) return 1'b0;
        if ((ca inside {OP_LOAD, OP_STORE}) && (cb inside {OP_LOAD, OP_STORE})) return 1'b0;
        return 1'b1;
    endfunction

    // issue groups in program order from start
    task automatic build_expected(input logic [31:0] start, input int n_insn);
        logic [31:0] pc;
        int          cnt;
        bit          two;
        grp_pc.delete();
        grp_two.delete();
        pc  = start;
        cnt = 0;
        while (cnt < n_insn) begin
            // an odd-word target arrives as a single word
            two = can_pair(word_at(pc), word_at(pc + 4)) && !(cnt == 0 && start[2]);
            grp_pc.push_back(pc);
            grp_two.push_back(two);
            cnt = cnt + (two ? 2 : 1);
            pc  = pc + (two ? 8 : 4);
        end
    endtask

    task automatic check_slot(input int s, input dec_slot_t got, input logic [31:0] pc);
        logic [31:0] w;
        string       tag;
        w   = word_at(pc);
        tag = $sformatf("issue_slot[%0d]", s);
        expect_eq({tag, ".valid"}, got.valid, 1'b1);
        expect_eq({tag, ".pc"}, got.pc, pc);
        expect_eq({tag, ".op"}, got.op, class_of(w));
        expect_eq({tag, ".rd"}, got.rd, w[11:7]);
        expect_eq({tag, ".rs1"}, got.rs1, w[19:15]);
        expect_eq({tag, ".rs2"}, got.rs2, w[24:20]);
        expect_eq({tag, ".writes_rd"}, got.writes_rd, writes_reg(w));
        expect_eq({tag, ".reads_rs2"}, got.reads_rs2, reads_second(w));
    endtask

    // outputs quiet while reset is held
    task automatic reset_quiet();
        expect_eq("imem_req", imem_req, 1'b0);
        expect_eq("issue_valid", issue_valid, 2'b00);
    endtask

    task automatic do_redirect(input logic [31:0] target);
        @(posedge clk);
        #1;
        stall       = 1'b0;
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        // nothing issues out of the redirect cycle
        expect_eq("issue_valid", issue_valid, 2'b00);
    endtask

    task automatic run_stream(input bit rnd, input int hold_at);
        int          g;
        int          idle;
        int          hold;
        bit          held;
        bit          prev;
        g    = 0;
        idle = 0;
        hold = 0;
        held = 1'b0;
        while (g < grp_pc.size()) begin
            @(posedge clk);
            #1;
            prev = stall;
            if (hold_at >= 0 && g >= hold_at && !held) begin
                hold = 30;
                held = 1'b1;
            end
            stall = (hold > 0) || (rnd && (($random(seed) & 3) == 0));
            if (hold > 0) hold = hold - 1;
            @(negedge clk);
            if (prev) begin
                expect_eq("issue_valid", issue_valid, 2'b00);
                idle = idle + 1;
            end else if (issue_valid != 2'b00) begin
                expect_eq("issue_valid", issue_valid, {grp_two[g], 1'b1});
                check_slot(0, issue_slot[0], grp_pc[g]);
                if (grp_two[g]) begin
                    check_slot(1, issue_slot[1], grp_pc[g] + 4);
                end
                g    = g + 1;
                idle = 0;
            end else begin
                idle = idle + 1;
            end
            assert (idle < 100)
            else abort_run($sformatf("no instruction issued for 100 cycles at group %0d", g));
        end
    endtask

    task automatic independent_alu();
        for (int i = 0; i < 8; i++) begin
            set_word(32'h100 + 4 * i, make_insn(ENC_OP, i + 1, i + 16, i + 24));
        end
        build_expected(32'h100, 8);
        do_redirect(32'h100);
        run_stream(1'b0, -1);
    endtask

    task automatic dependent_pair();
        logic [31:0] prog [10];
        // raw split, x0 writer kept, two memory ops split, rs2 raw split
        prog = '{make_insn(ENC_IMM, 5, 1, 0), make_insn(ENC_OP, 6, 5, 2),
                 make_insn(ENC_LOAD, 8, 3, 0), make_insn(ENC_IMM, 0, 4, 0),
                 make_insn(ENC_OP, 7, 0, 0), make_insn(ENC_LOAD, 10, 1, 0),
                 make_insn(ENC_STORE, 0, 3, 2), make_insn(ENC_IMM, 11, 13, 0),
                 make_insn(ENC_IMM, 12, 1, 0), make_insn(ENC_STORE, 0, 2, 12)};
        foreach (prog[i]) set_word(32'h200 + 4 * i, prog[i]);
        build_expected(32'h200, 12);
        do_redirect(32'h200);
        run_stream(1'b0, -1);
    endtask

    task automatic branch_slot0();
        logic [31:0] prog [6];
        prog = '{make_insn(ENC_BR, 0, 1, 2), make_insn(ENC_IMM, 3, 4, 0),
                 make_insn(ENC_IMM, 5, 6, 0), make_insn(ENC_JAL, 1, 0, 0),
                 make_insn(ENC_IMM, 7, 8, 0), make_insn(ENC_OP, 9, 10, 11)};
        foreach (prog[i]) set_word(32'h300 + 4 * i, prog[i]);
        build_expected(32'h300, 8);
        do_redirect(32'h300);
        run_stream(1'b0, -1);
    endtask

    task automatic stall_hold();
        build_expected(32'h400, 60);
        do_redirect(32'h400);
        run_stream(1'b0, 8);
    endtask

    task automatic odd_redirect();
        build_expected(32'h500, 12);
        do_redirect(32'h500);
        run_stream(1'b0, -1);
        build_expected(32'h604, 20);
        do_redirect(32'h604);
        run_stream(1'b0, -1);
    endtask

    task automatic random_program();
        logic [6:0] opcs [7];
        opcs = '{ENC_OP, ENC_IMM, ENC_LUI, ENC_LOAD, ENC_STORE, ENC_BR, ENC_SYS};
        // small register range so hazards are frequent
        for (int i = 0; i < 200; i++) begin
            set_word(32'h800 + 4 * i, make_insn(opcs[$unsigned($random(seed)) % 7],
                     $random(seed) & 7, $random(seed) & 7, $random(seed) & 7));
        end
        build_expected(32'h800, 200);
        do_redirect(32'h800);
        run_stream(1'b1, -1);
    endtask

    initial begin
        seed        = 32'h2a80e517;
        clk         = 1'b0;
        rstn        = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        imem_rdata  = '0;
        fill_memory();
        repeat (3) @(posedge clk);
        #1;
        reset_quiet();
        rstn = 1'b1;
        independent_alu();
        dependent_pair();
        branch_slot0();
        stall_hold();
        odd_redirect();
        random_program();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hw
hw/fe_pkg.sv
hw/fetch_unit.sv
hw/fetch_buffer.sv
hw/slot_decoder.sv
hw/issue_ctrl.sv
hw/frontend_top.sv
test/tb_frontend.sv

// File: Bender.yml
package:
  name: frontend

export_include_dirs:
  - hw

sources:
  - files:
      - hw/fe_pkg.sv
      - hw/fetch_unit.sv
      - hw/fetch_buffer.sv
      - hw/slot_decoder.sv
      - hw/issue_ctrl.sv
      - hw/frontend_top.sv
  - target: test
    files:
      - test/tb_frontend.sv
